/* all.f */
+incdir+logic
logic/raster_pkg.sv
logic/raster_prio_enc.sv
logic/raster_mem_streamer.sv
logic/raster_fetch_ctrl.sv
logic/raster_rs_dispatch.sv
logic/raster_mem.sv
sim/raster_mem_assertions.sv
sim/raster_mem_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the raster memory front end testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module raster_mem_tb \
    -f all.f -o raster_mem_sim \
    && ./obj_dir/raster_mem_sim | tee /dev/stderr | grep -q "All tests passed!" \
    && echo "Simulation PASSED" \
    || { echo "Simulation FAILED"; exit 1; }

/* sim/raster_mem_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "raster_defs.svh"

module raster_mem_tb
    import raster_pkg::*;
();

    localparam int mem_depth     = 1024;
    localparam int idle_timeout  = 20000;
    localparam int drain_timeout = 4000;
    localparam int num_jobs      = 8;

    logic                                 clk;
    logic                                 reset;
    logic                                 start;
    raster_cfg_t                          cfg;
    logic                                 idle;
    logic [`RASTER_SLICE_NUM-1:0]         slice_credit;
    logic                                 out_valid;
    raster_packet_t                       out_packet;
    logic [$clog2(`RASTER_SLICE_NUM)-1:0] out_slice;
    logic                                 mem_word_valid;
    logic [`RASTER_DATA_BITS-1:0]         mem_word_addr;
    logic                                 mem_rsp_word_valid;
    logic [`RASTER_DATA_BITS-1:0]         mem_rsp_word_data;

    logic [15:0]                  lfsr;
    int                           cycle;
    logic [`RASTER_DATA_BITS-1:0] mem_words [mem_depth];
    // Memory model response queue, oldest request first
    logic [`RASTER_DATA_BITS-1:0] mem_data_q [$];
    int                           mem_due_q [$];
    // Packets held by the slice model
    int                           hold_slice_q [$];
    int                           hold_due_q [$];
    int                           slice_held [`RASTER_SLICE_NUM];
    raster_packet_t               expected_q [$];
    int                           job_mem_words;

    raster_mem dut (
        .clk                (clk),
        .reset              (reset),
        .start              (start),
        .cfg                (cfg),
        .idle               (idle),
        .slice_credit       (slice_credit),
        .out_valid          (out_valid),
        .out_packet         (out_packet),
        .out_slice          (out_slice),
        .mem_word_valid     (mem_word_valid),
        .mem_word_addr      (mem_word_addr),
        .mem_rsp_word_valid (mem_rsp_word_valid),
        .mem_rsp_word_data  (mem_rsp_word_data)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // Galois form of x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 16'hB400;
        end
        return state >> 1;
    endfunction

    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr  = lfsr_step(lfsr);
            value = {value[30:0], lfsr[0]};
        end
        return value;
    endfunction

    function automatic logic [31:0] word_at(input logic [31:0] addr);
        return mem_words[addr[11:2]];
    endfunction

    task automatic report_failure(input string reason);
        $display("%s", reason);
        $display("Test failures found");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            report_failure($sformatf("[FAIL] %s: got 0x%h, expected 0x%h", name, got, expected));
        end
    endtask

    // Removes the matching expected packet, order across slots is free
    task automatic score_packet(input raster_packet_t got);
        int match;
        match = -1;
        for (int i = 0; i < expected_q.size(); i++) begin
            if (match < 0 && expected_q[i].x == got.x && expected_q[i].y == got.y
                && expected_q[i].pid == got.pid) begin
                match = i;
            end
        end
        if (match < 0) begin
            report_failure($sformatf("packet with pid 0x%h at x 0x%h, y 0x%h was not expected",
                                     got.pid, got.x, got.y));
        end else begin
            for (int r = 0; r < 3; r++) begin
                for (int c = 0; c < 3; c++) begin
                    check_value("out_packet.edges", got.edges[r][c],
                                expected_q[match].edges[r][c]);
                end
            end
            expected_q.delete(match);
        end
    endtask

    // Memory and slice models, run once per falling edge
    task automatic service_models();
        int i;
        int slice;
        cycle++;
        mem_rsp_word_valid = 1'b0;
        mem_rsp_word_data  = '0;
        if (mem_due_q.size() > 0 && mem_due_q[0] <= cycle) begin
            mem_rsp_word_valid = 1'b1;
            mem_rsp_word_data  = mem_data_q.pop_front();
            void'(mem_due_q.pop_front());
        end
        if (mem_word_valid) begin
            if (mem_word_addr[1:0] != 2'b00 || mem_word_addr >= 32'(mem_depth * 4)) begin
                report_failure($sformatf("memory request to 0x%h is outside the memory model",
                                         mem_word_addr));
            end
            mem_data_q.push_back(word_at(mem_word_addr));
            mem_due_q.push_back(cycle + 1 + int'(random_bits(3)));
            job_mem_words++;
            if (mem_due_q.size() > `RASTER_MEM_CREDITS) begin
                report_failure("more memory words are in flight than the memory credits allow");
            end
        end

        // At most one credit pulse per slice and cycle
        slice_credit = '0;
        i = 0;
        while (i < hold_due_q.size()) begin
            slice = hold_slice_q[i];
            if (hold_due_q[i] <= cycle && !slice_credit[slice]) begin
                slice_credit[slice] = 1'b1;
                slice_held[slice]--;
                hold_due_q.delete(i);
                hold_slice_q.delete(i);
            end else begin
                i++;
            end
        end
        if (out_valid) begin
            score_packet(out_packet);
            slice = int'(out_slice);
            slice_held[slice]++;
            if (slice_held[slice] > `RASTER_SLICE_CREDITS) begin
                report_failure("a slice received more packets than its credits allow");
            end
            // Long holds so that every slice runs out of credits now and then
            hold_slice_q.push_back(slice);
            hold_due_q.push_back(cycle + 64 + int'(random_bits(8)));
        end
    endtask

    task automatic next_cycle();
        @(negedge clk);
        service_models();
    endtask

    task automatic run_job(input int num_tiles);
        int             tbuf_idx;
        int             prims;
        int             total_words;
        int             waited;
        logic [31:0]    coord;
        logic [31:0]    pid;
        logic [31:0]    prim_addr;
        raster_packet_t want;
        cfg.num_tiles   = 32'(num_tiles);
        cfg.tbuf_base   = 4 * random_bits(6);
        cfg.pbuf_base   = 32'h400 + 4 * random_bits(6);
        cfg.pbuf_stride = 4 * (1 + random_bits(4));
        tbuf_idx    = int'(cfg.tbuf_base >> 2);
        total_words = 0;

        // Tile buffer holds coordinate, count, then one pid per primitive
        for (int t = 0; t < num_tiles; t++) begin
            coord = random_bits(32);
            prims = int'(random_bits(2));
            mem_words[tbuf_idx]     = coord;
            mem_words[tbuf_idx + 1] = 32'(prims);
            tbuf_idx    += 2;
            total_words += 2;
            for (int p = 0; p < prims; p++) begin
                pid = random_bits(4);
                mem_words[tbuf_idx] = pid;
                tbuf_idx++;
                prim_addr = cfg.pbuf_base + pid * cfg.pbuf_stride;
                want.x    = coord[15:0] << `RASTER_TILE_LOG2;
                want.y    = coord[31:16] << `RASTER_TILE_LOG2;
                want.pid  = pid;
                for (int r = 0; r < 3; r++) begin
                    for (int c = 0; c < 3; c++) begin
                        want.edges[r][c] = word_at(prim_addr + 32'(4 * (3 * r + c)));
                    end
                end
                expected_q.push_back(want);
                total_words += 1 + `RASTER_NUM_WORDS;
            end
        end
        job_mem_words = 0;

        waited = 0;
        while (!idle) begin
            next_cycle();
            waited++;
            if (waited > idle_timeout) begin
                report_failure("DUT never became idle to accept a new job");
            end
        end
        start = 1'b1;
        next_cycle();
        start = 1'b0;
        check_value("idle", 32'(idle), 32'h0);

        waited = 0;
        while (!idle) begin
            next_cycle();
            waited++;
            if (waited > idle_timeout) begin
                report_failure("job did not return to idle within the timeout");
            end
        end
        waited = 0;
        while (expected_q.size() > 0) begin
            next_cycle();
            waited++;
            if (waited > drain_timeout) begin
                report_failure("expected packets did not all arrive within the timeout");
            end
        end
        check_value("memory word count", 32'(job_mem_words), 32'(total_words));
    endtask

    initial begin
        int num_tiles;
        lfsr               = 16'd18889;
        cycle              = 0;
        reset              = 1'b1;
        start              = 1'b0;
        cfg                = '0;
        slice_credit       = '0;
        mem_rsp_word_valid = 1'b0;
        mem_rsp_word_data  = '0;
        job_mem_words      = 0;
        for (int s = 0; s < `RASTER_SLICE_NUM; s++) begin
            slice_held[s] = 0;
        end
        for (int i = 0; i < mem_depth; i++) begin
            mem_words[i] = random_bits(32);
        end

        repeat (2) @(negedge clk);
        reset = 1'b0;
        check_value("idle", 32'(idle), 32'h1);
        check_value("out_valid", 32'(out_valid), 32'h0);
        check_value("mem_word_valid", 32'(mem_word_valid), 32'h0);

        // Job 2 has no tiles and must not touch memory
        for (int job = 0; job < num_jobs; job++) begin
            if (job == 2) begin
                num_tiles = 0;
            end else begin
                num_tiles = 1 + int'(random_bits(2));
            end
            run_job(num_tiles);
        end

        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

/* sim/raster_mem_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

`include "raster_defs.svh"

module raster_mem_assertions (
    input logic                                 clk,
    input logic                                 reset,
    input logic                                 idle,
    input logic                                 out_valid,
    input logic [$clog2(`RASTER_SLICE_NUM)-1:0] out_slice,
    input logic [`RASTER_SLICE_NUM-1:0]         slice_credit,
    input logic                                 mem_word_valid,
    input logic                                 mem_rsp_word_valid
);

    localparam int mem_bits   = $clog2(`RASTER_MEM_CREDITS + 2);
    localparam int slice_bits = $clog2(`RASTER_SLICE_NUM);

    logic [mem_bits-1:0] mem_in_flight;
    logic [2:0]          slice_held [`RASTER_SLICE_NUM];

    // Words requested and not yet answered, packets not yet credited back
    always_ff @(posedge clk) begin
        if (reset) begin
            mem_in_flight <= '0;
            for (int s = 0; s < `RASTER_SLICE_NUM; s++) begin
                slice_held[s] <= '0;
            end
        end else begin
            mem_in_flight <= mem_in_flight + mem_bits'(mem_word_valid)
                           - mem_bits'(mem_rsp_word_valid);
            for (int s = 0; s < `RASTER_SLICE_NUM; s++) begin
                slice_held[s] <= slice_held[s] + 3'(out_valid && out_slice == slice_bits'(s))
                               - 3'(slice_credit[s]);
            end
        end
    end

    mem_credit_limit: assert property (@(posedge clk) disable iff (reset)
        mem_in_flight <= mem_bits'(`RASTER_MEM_CREDITS))
        else $error("memory words in flight exceed the memory credit count");

    for (genvar s = 0; s < `RASTER_SLICE_NUM; s++) begin : g_slice
        slice_credit_limit: assert property (@(posedge clk) disable iff (reset)
            slice_held[s] <= 3'(`RASTER_SLICE_CREDITS))
            else $error("slice %0d holds more packets than its credits", s);
    end

    reset_state: assert property (@(posedge clk)
        !reset && $past(reset) |-> idle && !out_valid && !mem_word_valid)
        else $error("outputs not in their reset state after reset");

    // Memory traffic only belongs to a running job
    mem_only_in_job: assert property (@(posedge clk) disable iff (reset)
        mem_word_valid |-> !idle)
        else $error("memory request issued while the front end is idle");

endmodule

bind raster_mem raster_mem_assertions assertions (
    .clk                (clk),
    .reset              (reset),
    .idle               (idle),
    .out_valid          (out_valid),
    .out_slice          (out_slice),
    .slice_credit       (slice_credit),
    .mem_word_valid     (mem_word_valid),
    .mem_rsp_word_valid (mem_rsp_word_valid)
);

`default_nettype wire

/* logic/raster_mem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "raster_defs.svh"

module raster_mem
    import raster_pkg::*;
(
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 start,
    input  raster_cfg_t                          cfg,
    output logic                                 idle,
    input  logic [`RASTER_SLICE_NUM-1:0]         slice_credit,
    output logic                                 out_valid,
    output raster_packet_t                       out_packet,
    output logic [$clog2(`RASTER_SLICE_NUM)-1:0] out_slice,
    output logic                                 mem_word_valid,
    output logic [`RASTER_DATA_BITS-1:0]         mem_word_addr,
    input  logic                                 mem_rsp_word_valid,
    input  logic [`RASTER_DATA_BITS-1:0]         mem_rsp_word_data
);

    logic           req_valid;
    logic           req_ready;
    mem_req_t       req;
    logic           rsp_valid;
    mem_rsp_t       rsp;
    logic           rs_has_free;
    logic           rs_push;
    raster_packet_t rs_packet;

    // Walks tiles and primitives, builds packets
    raster_fetch_ctrl fetch_ctrl (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .cfg         (cfg),
        .idle        (idle),
        .req_valid   (req_valid),
        .req         (req),
        .req_ready   (req_ready),
        .rsp_valid   (rsp_valid),
        .rsp         (rsp),
        .rs_has_free (rs_has_free),
        .rs_push     (rs_push),
        .rs_packet   (rs_packet)
    );

    raster_mem_streamer mem_streamer (
        .clk                (clk),
        .reset              (reset),
        .req_valid          (req_valid),
        .req                (req),
        .req_ready          (req_ready),
        .rsp_valid          (rsp_valid),
        .rsp                (rsp),
        .mem_word_valid     (mem_word_valid),
        .mem_word_addr      (mem_word_addr),
        .mem_rsp_word_valid (mem_rsp_word_valid),
        .mem_rsp_word_data  (mem_rsp_word_data)
    );

    // Packets wait here for a slice with credit
    raster_rs_dispatch rs_dispatch (
        .clk          (clk),
        .reset        (reset),
        .push         (rs_push),
        .push_packet  (rs_packet),
        .has_free     (rs_has_free),
        .slice_credit (slice_credit),
        .out_valid    (out_valid),
        .out_packet   (out_packet),
        .out_slice    (out_slice)
    );

endmodule

`default_nettype wire

/* logic/raster_rs_dispatch.sv */
`timescale 1ns/1ps
`default_nettype none

`include "raster_defs.svh"

module raster_rs_dispatch
    import raster_pkg::*;
(
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 push,
    input  raster_packet_t                       push_packet,
    output logic                                 has_free,
    input  logic [`RASTER_SLICE_NUM-1:0]         slice_credit,
    output logic                                 out_valid,
    output raster_packet_t                       out_packet,
    output logic [$clog2(`RASTER_SLICE_NUM)-1:0] out_slice
);

    localparam int rs_bits     = $clog2(`RASTER_RS_SIZE);
    localparam int slice_bits  = $clog2(`RASTER_SLICE_NUM);
    localparam int credit_bits = $clog2(`RASTER_SLICE_CREDITS + 1);

    raster_packet_t               entries [`RASTER_RS_SIZE];
    logic [`RASTER_RS_SIZE-1:0]   entry_valid;
    logic [rs_bits-1:0]           free_idx;
    logic [rs_bits-1:0]           head_idx;
    logic                         head_found;
    logic [credit_bits-1:0]       credits [`RASTER_SLICE_NUM];
    logic [`RASTER_SLICE_NUM-1:0] slice_ready;
    logic [slice_bits-1:0]        slice_idx;
    logic                         slice_found;
    logic                         dispatch;

    raster_prio_enc #(.n(`RASTER_RS_SIZE)) free_enc (
        .bits  (~entry_valid),
        .index (free_idx),
        .found (has_free)
    );

    // Not FIFO order, the lowest occupied slot goes first
    raster_prio_enc #(.n(`RASTER_RS_SIZE)) head_enc (
        .bits  (entry_valid),
        .index (head_idx),
        .found (head_found)
    );

    always_comb begin
        for (int s = 0; s < `RASTER_SLICE_NUM; s++) begin
            slice_ready[s] = (credits[s] != '0);
        end
    end

    raster_prio_enc #(.n(`RASTER_SLICE_NUM)) slice_enc (
        .bits  (slice_ready),
        .index (slice_idx),
        .found (slice_found)
    );

    assign dispatch = head_found && slice_found;

    always_ff @(posedge clk) begin
        if (reset) begin
            entry_valid <= '0;
            out_valid   <= 1'b0;
            for (int s = 0; s < `RASTER_SLICE_NUM; s++) begin
                credits[s] <= credit_bits'(`RASTER_SLICE_CREDITS);
            end
        end else begin
            out_valid <= dispatch;
            // Push and dispatch never touch the same slot
            if (push) begin
                entry_valid[free_idx] <= 1'b1;
            end
            if (dispatch) begin
                entry_valid[head_idx] <= 1'b0;
            end
            for (int s = 0; s < `RASTER_SLICE_NUM; s++) begin
                case ({dispatch && (slice_idx == slice_bits'(s)), slice_credit[s]})
                    2'b10:   credits[s] <= credits[s] - 1'b1;
                    2'b01:   credits[s] <= credits[s] + 1'b1;
                    default: credits[s] <= credits[s];
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entries[free_idx] <= push_packet;
        end
        if (dispatch) begin
            out_packet <= entries[head_idx];
            out_slice  <= slice_idx;
        end
    end

endmodule

`default_nettype wire

/* logic/raster_fetch_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "raster_defs.svh"

module raster_fetch_ctrl
    import raster_pkg::*;
(
    input  logic           clk,
    input  logic           reset,
    input  logic           start,
    input  raster_cfg_t    cfg,
    output logic           idle,
    output logic           req_valid,
    output mem_req_t       req,
    input  logic           req_ready,
    input  logic           rsp_valid,
    input  mem_rsp_t       rsp,
    input  logic           rs_has_free,
    output logic           rs_push,
    output raster_packet_t rs_packet
);

    localparam int num_words = `RASTER_NUM_WORDS;
    localparam logic [`RASTER_DATA_BITS-1:0] word_bytes = `RASTER_DATA_BITS'(4);

    typedef enum logic [2:0] {
        s_idle,
        s_next_tile,
        s_tile_req,
        s_next_prim,
        s_pid_req,
        s_data_req,
        s_wait
    } state_e;

    state_e                       state;
    raster_cfg_t                  cfg_q;
    logic [`RASTER_DATA_BITS-1:0] tbuf_ptr;
    logic [`RASTER_DATA_BITS-1:0] tile_cnt;
    logic [`RASTER_DATA_BITS-1:0] prim_cnt;
    logic [`RASTER_DATA_BITS-1:0] num_prims;
    logic [`RASTER_DIM_BITS-1:0]  tile_x;
    logic [`RASTER_DIM_BITS-1:0]  tile_y;
    logic [`RASTER_DATA_BITS-1:0] pid;
    logic [`RASTER_DATA_BITS-1:0] prim_base;
    tile_word_u                   tile_word;

    assign idle          = (state == s_idle);
    assign tile_word.raw = rsp.data[0];

    always_comb begin
        req       = '0;
        req_valid = 1'b0;
        case (state)
            s_tile_req: begin
                // Header is the coordinate word then the primitive count
                req_valid   = 1'b1;
                req.kind    = fetch_tile;
                req.mask    = num_words'(2'b11);
                req.addr[0] = tbuf_ptr;
                req.addr[1] = tbuf_ptr + word_bytes;
            end
            s_pid_req: begin
                req_valid   = 1'b1;
                req.kind    = fetch_pid;
                req.mask    = num_words'(1'b1);
                req.addr[0] = tbuf_ptr;
            end
            s_data_req: begin
                // Only one packet is ever in flight, so a free entry now stays free
                req_valid = rs_has_free;
                req.kind  = fetch_prim_data;
                req.mask  = '1;
                for (int i = 0; i < num_words; i++) begin
                    req.addr[i] = prim_base + `RASTER_DATA_BITS'(4 * i);
                end
            end
            default: begin
            end
        endcase
    end

    assign rs_push = (state == s_wait) && rsp_valid && (rsp.kind == fetch_prim_data);

    always_comb begin
        rs_packet.x     = tile_x;
        rs_packet.y     = tile_y;
        // Nine words map row by row onto the 3x3 edge array
        rs_packet.edges = rsp.data;
        rs_packet.pid   = pid;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= s_idle;
            tbuf_ptr <= '0;
            tile_cnt <= '0;
            prim_cnt <= '0;
        end else begin
            case (state)
                s_idle: begin
                    if (start) begin
                        tbuf_ptr <= cfg.tbuf_base;
                        tile_cnt <= '0;
                        state    <= s_next_tile;
                    end
                end
                s_next_tile: begin
                    state <= (tile_cnt == cfg_q.num_tiles) ? s_idle : s_tile_req;
                end
                s_tile_req: begin
                    if (req_ready) begin
                        tbuf_ptr <= tbuf_ptr + 2 * word_bytes;
                        state    <= s_wait;
                    end
                end
                s_next_prim: begin
                    if (prim_cnt == num_prims) begin
                        tile_cnt <= tile_cnt + 1'b1;
                        state    <= s_next_tile;
                    end else begin
                        state <= s_pid_req;
                    end
                end
                s_pid_req: begin
                    if (req_ready) begin
                        tbuf_ptr <= tbuf_ptr + word_bytes;
                        state    <= s_wait;
                    end
                end
                s_data_req: begin
                    if (req_valid && req_ready) begin
                        state <= s_wait;
                    end
                end
                s_wait: begin
                    if (rsp_valid) begin
                        case (rsp.kind)
                            fetch_tile: begin
                                prim_cnt <= '0;
                                state    <= s_next_prim;
                            end
                            fetch_pid: state <= s_data_req;
                            default: begin
                                prim_cnt <= prim_cnt + 1'b1;
                                state    <= s_next_prim;
                            end
                        endcase
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (idle && start) begin
            cfg_q <= cfg;
        end
        if (state == s_wait && rsp_valid && rsp.kind == fetch_tile) begin
            tile_x    <= tile_word.xy.x << `RASTER_TILE_LOG2;
            tile_y    <= tile_word.xy.y << `RASTER_TILE_LOG2;
            num_prims <= rsp.data[1];
        end
        if (state == s_wait && rsp_valid && rsp.kind == fetch_pid) begin
            pid       <= rsp.data[0];
            prim_base <= cfg_q.pbuf_base + rsp.data[0] * cfg_q.pbuf_stride;
        end
    end

endmodule

`default_nettype wire

/* logic/raster_mem_streamer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "raster_defs.svh"

module raster_mem_streamer
    import raster_pkg::*;
(
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         req_valid,
    input  mem_req_t                     req,
    output logic                         req_ready,
    output logic                         rsp_valid,
    output mem_rsp_t                     rsp,
    output logic                         mem_word_valid,
    output logic [`RASTER_DATA_BITS-1:0] mem_word_addr,
    input  logic                         mem_rsp_word_valid,
    input  logic [`RASTER_DATA_BITS-1:0] mem_rsp_word_data
);

    localparam int num_words = `RASTER_NUM_WORDS;
    localparam int idx_bits  = $clog2(num_words);
    localparam int cnt_bits  = $clog2(`RASTER_MEM_CREDITS + 1);

    function automatic logic [idx_bits-1:0] lowest_index(input logic [num_words-1:0] mask);
        logic [idx_bits-1:0] idx;
        idx = '0;
        for (int i = num_words - 1; i >= 0; i--) begin
            if (mask[i]) begin
                idx = idx_bits'(i);
            end
        end
        return idx;
    endfunction

    function automatic logic [cnt_bits-1:0] count_ones(input logic [num_words-1:0] mask);
        logic [cnt_bits-1:0] total;
        total = '0;
        for (int i = 0; i < num_words; i++) begin
            total = total + cnt_bits'(mask[i]);
        end
        return total;
    endfunction

    logic                 busy;
    mem_req_t             req_q;
    logic [num_words-1:0] issue_mask;
    logic [num_words-1:0] fill_mask;
    logic [idx_bits-1:0]  issue_idx;
    logic [idx_bits-1:0]  fill_idx;
    logic [cnt_bits-1:0]  word_total;
    // Words issued and not yet released by a consumed response
    logic [cnt_bits-1:0]  held_words;
    logic [num_words-1:0][`RASTER_DATA_BITS-1:0] rsp_data;

    assign issue_idx = lowest_index(issue_mask);
    assign fill_idx  = lowest_index(fill_mask);

    assign req_ready      = !busy;
    assign mem_word_valid = busy && (issue_mask != '0)
                          && (held_words < cnt_bits'(`RASTER_MEM_CREDITS));
    assign mem_word_addr  = req_q.addr[issue_idx];

    // Complete once every masked word was sent and has come back
    assign rsp_valid = busy && (issue_mask == '0) && (fill_mask == '0);

    always_comb begin
        rsp.data = rsp_data;
        rsp.kind = req_q.kind;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy       <= 1'b0;
            issue_mask <= '0;
            fill_mask  <= '0;
            held_words <= '0;
        end else begin
            if (req_valid && req_ready) begin
                busy       <= 1'b1;
                issue_mask <= req.mask;
                fill_mask  <= req.mask;
            end
            if (mem_word_valid) begin
                issue_mask[issue_idx] <= 1'b0;
            end
            // Memory returns in order so words land in the lowest open slot
            if (mem_rsp_word_valid) begin
                fill_mask[fill_idx] <= 1'b0;
            end
            if (rsp_valid) begin
                busy <= 1'b0;
            end
            held_words <= held_words + cnt_bits'(mem_word_valid)
                        - (rsp_valid ? word_total : '0);
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            req_q      <= req;
            word_total <= count_ones(req.mask);
        end
        if (mem_rsp_word_valid) begin
            rsp_data[fill_idx] <= mem_rsp_word_data;
        end
    end

endmodule

`default_nettype wire

/* logic/raster_prio_enc.sv */
`timescale 1ns/1ps
`default_nettype none

// Lowest set bit wins
module raster_prio_enc #(
    parameter int n = 8,
    localparam int idx_bits = (n > 1) ? $clog2(n) : 1
) (
    input  logic [n-1:0]        bits,
    output logic [idx_bits-1:0] index,
    output logic                found
);

    always_comb begin
        index = '0;
        found = 1'b0;
        // Walk downwards so the lowest index is assigned last
        for (int i = n - 1; i >= 0; i--) begin
            if (bits[i]) begin
                index = idx_bits'(i);
                found = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/raster_pkg.sv */
`default_nettype none

`include "raster_defs.svh"

package raster_pkg;

    // Encodings follow the tag values used by the fetch sequence
    typedef enum logic [1:0] {
        fetch_tile      = 2'b01,
        fetch_pid       = 2'b10,
        fetch_prim_data = 2'b11
    } fetch_kind_e;

    // Tile header coordinate word, y in the upper half
    typedef struct packed {
        logic [`RASTER_DIM_BITS-1:0] y;
        logic [`RASTER_DIM_BITS-1:0] x;
    } tile_xy_t;

    typedef union packed {
        logic [`RASTER_DATA_BITS-1:0] raw;
        tile_xy_t                     xy;
    } tile_word_u;

    typedef struct packed {
        logic [`RASTER_NUM_WORDS-1:0][`RASTER_DATA_BITS-1:0] addr;
        logic [`RASTER_NUM_WORDS-1:0]                        mask;
        fetch_kind_e                                         kind;
    } mem_req_t;

    typedef struct packed {
        logic [`RASTER_NUM_WORDS-1:0][`RASTER_DATA_BITS-1:0] data;
        fetch_kind_e                                         kind;
    } mem_rsp_t;

    typedef struct packed {
        logic [`RASTER_DIM_BITS-1:0]            x;
        logic [`RASTER_DIM_BITS-1:0]            y;
        logic [2:0][2:0][`RASTER_DATA_BITS-1:0] edges;
        logic [`RASTER_DATA_BITS-1:0]           pid;
    } raster_packet_t;

    typedef struct packed {
        logic [`RASTER_DATA_BITS-1:0] num_tiles;
        logic [`RASTER_DATA_BITS-1:0] tbuf_base;
        logic [`RASTER_DATA_BITS-1:0] pbuf_base;
        logic [`RASTER_DATA_BITS-1:0] pbuf_stride;
    } raster_cfg_t;

endpackage

`default_nettype wire

/* logic/raster_defs.svh */
`ifndef RASTER_DEFS_SVH
`define RASTER_DEFS_SVH

// Word and coordinate widths
`define RASTER_DATA_BITS     32
`define RASTER_DIM_BITS      16

// Edge coefficients fetched per primitive
`define RASTER_NUM_WORDS     9

// Reservation station and slice side
`define RASTER_RS_SIZE       8
`define RASTER_SLICE_NUM     4
`define RASTER_SLICE_CREDITS 2

// Memory words allowed in flight
`define RASTER_MEM_CREDITS   12

// Tile index to pixel coordinate
`define RASTER_TILE_LOG2     4

`endif
